//--- verilog.f
+incdir+.
router_pkg.sv
input_port.sv
switch_alloc.sv
credit_counter.sv
crossbar.sv
router.sv
router_checker.sv
router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the router testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module router_tb -o router_sim
./obj_dir/router_sim | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation did not pass"
  exit 1
fi

//--- router_tb.sv
// router testbench
// table-driven flits, credit-respecting upstream and downstream models, watchdog

`include "router_params.svh"

`default_nettype none

module router_tb import router_pkg::*; ();

  localparam logic [2:0] T_RESET = 3'd0;
  localparam logic [2:0] T_ROUTE = 3'd1;
  localparam logic [2:0] T_LAT   = 3'd2;
  localparam logic [2:0] T_CONT  = 3'd3;
  localparam logic [2:0] T_BP    = 3'd4;
  localparam logic [2:0] T_BPREL = 3'd5;
  localparam logic [2:0] T_FILL  = 3'd6;
  localparam int         FILL_ROWS = 24;

  // gap 0 puts the next row in the same cycle
  typedef struct packed {
    logic [2:0] test;
    port_e      src;
    coord_t     dx;
    coord_t     dy;
    payload_t   payload;
    logic [1:0] gap;
  } row_t;

  logic            clk;
  logic            rst_n_i;
  flit_t     [4:0] flit_i;
  port_vec_t       credit_o;
  flit_t     [4:0] flit_o;
  port_vec_t       credit_i;
  logic      [2:0] test_id;
  logic            done;
  logic            check_done;
  int              err_cnt;
  int              pending;
  port_vec_t       cred_en;
  int              up_cred [5];
  int              owed [5];
  row_t            tbl [$];
  bit              tbl_ready;

  router #(.ROUTER_X(coord_t'(1)), .ROUTER_Y(coord_t'(1))) uut (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .flit_i   (flit_i),
    .credit_o (credit_o),
    .flit_o   (flit_o),
    .credit_i (credit_i)
  );

  router_checker #(.ROUTER_X(coord_t'(1)), .ROUTER_Y(coord_t'(1))) chk (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flit_i       (flit_i),
    .credit_o     (credit_o),
    .flit_o       (flit_o),
    .test_id_i    (test_id),
    .done_i       (done),
    .err_cnt_o    (err_cnt),
    .pending_o    (pending),
    .check_done_o (check_done)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic add_row(input logic [2:0] test, input port_e src, input coord_t dx,
                         input coord_t dy, input payload_t pl, input logic [1:0] gap);
    tbl.push_back({test, src, dx, dy, pl, gap});
  endtask

  // router sits at (1,1)
  task automatic build_table();
    logic [31:0] seed;
    logic [3:0]  src4;
    add_row(T_ROUTE, PORT_L, 2'd2, 2'd1, 16'h1001, 2'd1);
    add_row(T_ROUTE, PORT_L, 2'd0, 2'd1, 16'h1002, 2'd1);
    add_row(T_ROUTE, PORT_L, 2'd1, 2'd2, 16'h1003, 2'd1);
    add_row(T_ROUTE, PORT_L, 2'd1, 2'd0, 16'h1004, 2'd1);
    add_row(T_ROUTE, PORT_L, 2'd1, 2'd1, 16'h1005, 2'd1);
    // x wins over y
    add_row(T_ROUTE, PORT_N, 2'd3, 2'd0, 16'h1006, 2'd1);
    add_row(T_ROUTE, PORT_S, 2'd0, 2'd3, 16'h1007, 2'd1);
    add_row(T_LAT,   PORT_W, 2'd2, 2'd1, 16'h2001, 2'd1);
    // everyone into local
    add_row(T_CONT,  PORT_N, 2'd1, 2'd1, 16'h3001, 2'd0);
    add_row(T_CONT,  PORT_S, 2'd1, 2'd1, 16'h3002, 2'd0);
    add_row(T_CONT,  PORT_E, 2'd1, 2'd1, 16'h3003, 2'd0);
    add_row(T_CONT,  PORT_W, 2'd1, 2'd1, 16'h3004, 2'd1);
    add_row(T_CONT,  PORT_N, 2'd1, 2'd1, 16'h3005, 2'd0);
    add_row(T_CONT,  PORT_S, 2'd1, 2'd1, 16'h3006, 2'd0);
    add_row(T_CONT,  PORT_E, 2'd1, 2'd1, 16'h3007, 2'd1);
    add_row(T_CONT,  PORT_N, 2'd1, 2'd1, 16'h3008, 2'd1);
    // more east traffic than east credits
    for (int i = 0; i < 6; i++) begin
      add_row(T_BP, PORT_L, 2'd3, 2'd1, 16'h4001 + 16'(i), 2'd1);
    end
    add_row(T_BP,    PORT_N, 2'd2, 2'd0, 16'h4007, 2'd1);
    seed = 32'h8828_a3b6;
    for (int i = 0; i < FILL_ROWS; i++) begin
      seed = lcg_next(seed);
      src4 = seed[31:28] % 4'd5;
      add_row(T_FILL, port_e'(src4[2:0]), seed[27:26], seed[25:24], 16'h6000 + 16'(i),
              seed[21:20]);
    end
  endtask

  // rows of one test, grouped per cycle, held back while an input has no credit
  task automatic run_test(input logic [2:0] id);
    int          r;
    int          last;
    int          gap;
    bit          grp_done;
    flit_t [4:0] cyc;
    port_vec_t   used;
    row_t        row;
    test_id = id;
    r = 0;
    while (r < tbl.size() && tbl[r].test != id) r++;
    last = r;
    while (last < tbl.size() && tbl[last].test == id) last++;
    while (r < last) begin
      cyc      = '0;
      used     = '0;
      grp_done = 1'b0;
      gap      = 1;
      while (!grp_done && r < last) begin
        row = tbl[r];
        if (used[row.src] || up_cred[row.src] == 0) begin
          grp_done = 1'b1;
        end else begin
          cyc[row.src]  = {1'b1, row.dx, row.dy, row.payload};
          used[row.src] = 1'b1;
          gap           = int'(row.gap);
          grp_done      = (row.gap != 2'd0);
          r++;
        end
      end
      flit_i = cyc;
      step();
      flit_i = '0;
      repeat ((gap > 1) ? gap - 1 : 0) step();
    end
  endtask

  function automatic int owed_total();
    int s;
    s = 0;
    for (int o = 0; o < 5; o++) s += owed[o];
    return s;
  endfunction

  // everything delivered and every downstream credit handed back
  task automatic drain();
    while (pending != 0 || owed_total() != 0) step();
    repeat (3) step();
  endtask

  // upstream credit view per input
  initial begin
    forever begin
      @(posedge clk);
      for (int p = 0; p < 5; p++) begin
        if (!rst_n_i) up_cred[p] = `ROUTER_FIFO_DEPTH;
        else up_cred[p] = up_cred[p] + int'(credit_o[p]) - int'(flit_i[p].valid);
      end
    end
  end

  // downstream neighbours, one credit back per delivered flit
  initial begin
    port_vec_t ret;
    credit_i = '0;
    forever begin
      @(posedge clk);
      for (int o = 0; o < 5; o++) begin
        ret[o] = 1'b0;
        if (!rst_n_i) begin
          owed[o] = 0;
        end else begin
          if (flit_o[o].valid) owed[o]++;
          if (cred_en[o] && owed[o] > 0) begin
            ret[o] = 1'b1;
            owed[o]--;
          end
        end
      end
      #2;
      credit_i = ret;
    end
  end

  initial begin
    int limit;
    wait (tbl_ready);
    limit = tbl.size() * 20 + 300;
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Something failed");
    $finish;
  end

  initial begin
    rst_n_i   = 1'b0;
    flit_i    = '0;
    test_id   = T_RESET;
    done      = 1'b0;
    cred_en   = '1;
    tbl_ready = 1'b0;
    build_table();
    tbl_ready = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n_i = 1'b1;
    // quiet window for the idle check
    repeat (3) step();
    run_test(T_ROUTE);
    drain();
    run_test(T_LAT);
    drain();
    run_test(T_CONT);
    drain();
    cred_en[PORT_E] = 1'b0;
    run_test(T_BP);
    repeat (20) step();
    test_id         = T_BPREL;
    cred_en[PORT_E] = 1'b1;
    drain();
    run_test(T_FILL);
    drain();
    done = 1'b1;
    while (!check_done) step();
    $display("closing report: %0d errors counted", err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- router_checker.sv
// router scoreboard
// predicts each flit's output by the xy rule, matches deliveries, counts errors

`include "router_params.svh"

`default_nettype none

module router_checker import router_pkg::*; #(
  parameter coord_t ROUTER_X = '0,
  parameter coord_t ROUTER_Y = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  flit_t     [4:0] flit_i,
  input  port_vec_t       credit_o,
  input  flit_t     [4:0] flit_o,
  input  logic      [2:0] test_id_i,
  input  logic            done_i,
  output int              err_cnt_o,
  output int              pending_o,
  output logic            check_done_o
);

  localparam logic [2:0] T_RESET = 3'd0;
  localparam logic [2:0] T_LAT   = 3'd2;
  localparam logic [2:0] T_BP    = 3'd4;

  // one flit still owed by the router
  typedef struct packed {
    logic [2:0]  test;
    port_e       src;
    port_e       dst;
    payload_t    payload;
    logic [31:0] cyc;
  } exp_t;

  exp_t        exp_q [$];
  int          sent_cnt [5];
  int          cred_cnt [5];
  int          bp_cnt;
  logic [2:0]  prev_test;
  logic [31:0] cyc;

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd0:    return "reset";
      3'd1:    return "routing";
      3'd2:    return "latency";
      3'd3:    return "contention";
      3'd4:    return "backpressure";
      3'd5:    return "bp_release";
      default: return "filler";
    endcase
  endfunction

  // dimension order, x before y
  function automatic port_e xy_port(coord_t dx, coord_t dy);
    if (dx > ROUTER_X) return PORT_E;
    if (dx < ROUTER_X) return PORT_W;
    if (dy > ROUTER_Y) return PORT_N;
    if (dy < ROUTER_Y) return PORT_S;
    return PORT_L;
  endfunction

  task automatic match_flit(input int o);
    int hit;
    int first;
    hit   = -1;
    first = -1;
    for (int k = 0; k < exp_q.size(); k++) begin
      if (exp_q[k].dst == port_e'(3'(o))) begin
        if (first < 0) first = k;
        if (hit < 0 && exp_q[k].payload == flit_o[o].payload) hit = k;
      end
    end
    if (hit < 0) begin
      err_cnt_o++;
      if (first < 0) begin
        $display("unexpected flit %h on output %0d, nothing was sent there",
                 flit_o[o].payload, o);
      end else begin
        $display("ERR %s: expected %h, actual %h", test_name(exp_q[first].test),
                 exp_q[first].payload, flit_o[o].payload);
      end
    end else begin
      // an older flit from the same input must leave first
      for (int k = 0; k < hit; k++) begin
        if (exp_q[k].src == exp_q[hit].src) begin
          err_cnt_o++;
          $display("ERR %s: expected %h, actual %h", test_name(exp_q[hit].test),
                   exp_q[k].payload, flit_o[o].payload);
        end
      end
      // input seen at edge n, output seen at edge n+2
      if (exp_q[hit].test == T_LAT && cyc - exp_q[hit].cyc != 32'd2) begin
        err_cnt_o++;
        $display("ERR latency: expected %0d, actual %0d", 2, cyc - exp_q[hit].cyc);
      end
      exp_q.delete(hit);
    end
  endtask

  task automatic final_checks();
    foreach (exp_q[k]) begin
      err_cnt_o++;
      $display("missing flit: payload %h from test %s never left output %0d",
               exp_q[k].payload, test_name(exp_q[k].test), exp_q[k].dst);
    end
    // every departure from an input fifo returns one credit upstream
    for (int p = 0; p < 5; p++) begin
      if (cred_cnt[p] != sent_cnt[p]) begin
        err_cnt_o++;
        $display("ERR credit_return: expected %0d, actual %0d", sent_cnt[p], cred_cnt[p]);
      end
    end
  endtask

  always @(posedge clk) begin
    port_vec_t vld;
    exp_t      e;
    if (!rst_n_i) begin
      exp_q.delete();
      for (int p = 0; p < 5; p++) begin
        sent_cnt[p] = 0;
        cred_cnt[p] = 0;
      end
      cyc          = '0;
      bp_cnt       = 0;
      prev_test    = T_RESET;
      err_cnt_o    = 0;
      check_done_o = 1'b0;
    end else begin
      cyc = cyc + 32'd1;
      for (int o = 0; o < 5; o++) begin
        vld[o] = flit_o[o].valid;
      end
      // idle router out of reset
      if (test_id_i == T_RESET && (vld != '0 || credit_o != '0)) begin
        err_cnt_o++;
        $display("ERR reset: expected %h, actual %h", 10'h0, {vld, credit_o});
      end
      for (int p = 0; p < 5; p++) begin
        if (flit_i[p].valid) begin
          e.test    = test_id_i;
          e.src     = port_e'(3'(p));
          e.dst     = xy_port(flit_i[p].dest_x, flit_i[p].dest_y);
          e.payload = flit_i[p].payload;
          e.cyc     = cyc;
          exp_q.push_back(e);
          sent_cnt[p]++;
        end
        if (credit_o[p]) cred_cnt[p]++;
      end
      for (int o = 0; o < 5; o++) begin
        if (vld[o]) match_flit(o);
      end
      // east may send only its initial credits while returns are held
      if (test_id_i == T_BP && vld[PORT_E]) bp_cnt++;
      if (prev_test == T_BP && test_id_i != T_BP && bp_cnt != `ROUTER_FIFO_DEPTH) begin
        err_cnt_o++;
        $display("ERR backpressure: expected %0d, actual %0d", `ROUTER_FIFO_DEPTH, bp_cnt);
      end
      prev_test = test_id_i;
      if (done_i && !check_done_o) begin
        final_checks();
        check_done_o = 1'b1;
      end
    end
    pending_o = exp_q.size();
  end

endmodule

`default_nettype wire

//--- router.sv
// five-port mesh router top
// input ports, switch allocator, output credit counters and crossbar

`default_nettype none

module router import router_pkg::*; #(
  parameter coord_t ROUTER_X = '0,
  parameter coord_t ROUTER_Y = '0
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  flit_t     [4:0] flit_i,
  output port_vec_t       credit_o,
  output flit_t     [4:0] flit_o,
  input  port_vec_t       credit_i
);

  // per-input head flit and route request
  flit_t     [4:0] head;
  port_vec_t [4:0] req;

  // allocator results
  port_vec_t       gnt_in;
  port_vec_t       gnt_out;
  port_e     [4:0] sel;

  // per-output downstream space
  port_vec_t       has_credit;

  for (genvar p = 0; p < 5; p++) begin : g_port
    // input side of port p, popped by its grant
    input_port #(
      .MY_X (ROUTER_X),
      .MY_Y (ROUTER_Y)
    ) u_input_port (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .flit_i   (flit_i[p]),
      .pop_i    (gnt_in[p]),
      .head_o   (head[p]),
      .req_o    (req[p]),
      .credit_o (credit_o[p])
    );

    // output side of port p
    credit_counter u_credit_counter (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .send_i       (gnt_out[p]),
      .credit_i     (credit_i[p]),
      .has_credit_o (has_credit[p])
    );
  end

  switch_alloc u_switch_alloc (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_i       (req),
    .credit_ok_i (has_credit),
    .gnt_in_o    (gnt_in),
    .gnt_out_o   (gnt_out),
    .sel_o       (sel)
  );

  crossbar u_crossbar (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .head_i    (head),
    .gnt_out_i (gnt_out),
    .sel_i     (sel),
    .flit_o    (flit_o)
  );

endmodule

`default_nettype wire

//--- crossbar.sv
// registered crossbar
// each output captures the head flit of its granted input

`default_nettype none

module crossbar import router_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  flit_t     [4:0] head_i,
  input  port_vec_t       gnt_out_i,
  input  port_e     [4:0] sel_i,
  output flit_t     [4:0] flit_o
);

  port_vec_t   valid_q;
  flit_t [4:0] data_q;

  // valid is control, one cycle per grant
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= gnt_out_i;
    end
  end

  // payload only loads on a grant
  always_ff @(posedge clk) begin
    for (int o = 0; o < 5; o++) begin
      if (gnt_out_i[o]) begin
        data_q[o] <= head_i[sel_i[o]];
      end
    end
  end

  always_comb begin
    for (int o = 0; o < 5; o++) begin
      flit_o[o]       = data_q[o];
      flit_o[o].valid = valid_q[o];
    end
  end

endmodule

`default_nettype wire

//--- credit_counter.sv
// output credit counter
// tracks free downstream slots, down on send, up on returned credit

`include "router_params.svh"

`default_nettype none

module credit_counter (
  input  logic clk,
  input  logic rst_n_i,
  input  logic send_i,
  input  logic credit_i,
  output logic has_credit_o
);

  localparam logic [`ROUTER_CRED_W-1:0] FULL_CNT = `ROUTER_FIFO_DEPTH;

  logic [`ROUTER_CRED_W-1:0] cnt_q;

  // downstream starts with an empty fifo
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q <= FULL_CNT;
    end else begin
      case ({send_i, credit_i})
        2'b10:   cnt_q <= cnt_q - 1'b1;
        2'b01:   cnt_q <= cnt_q + 1'b1;
        // send and return in one cycle cancel out
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  assign has_credit_o = (cnt_q != '0);

  // allocator gating keeps sends away from an empty counter
  a_no_send_at_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(send_i && !credit_i && cnt_q == '0));

  // downstream never returns more than it was sent
  a_no_over_return: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(credit_i && !send_i && cnt_q == FULL_CNT));

endmodule

`default_nettype wire

//--- switch_alloc.sv
// switch allocator
// round-robin pick per output among requesting inputs, gated by downstream credit

`default_nettype none

module switch_alloc import router_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,
  input  port_vec_t [4:0] req_i,
  input  port_vec_t       credit_ok_i,
  output port_vec_t       gnt_in_o,
  output port_vec_t       gnt_out_o,
  output port_e     [4:0] sel_o
);

  // per-output priority pointer
  port_e [4:0] rr_q;

  // inputs asking for more than one output
  port_vec_t req_multi;

  // one request hit per output
  port_vec_t found;

  // wrap from local back to north
  function automatic port_e port_inc(port_e p);
    return (p == PORT_L) ? PORT_N : port_e'(p + 3'd1);
  endfunction

  always_comb begin
    port_e cand;
    gnt_in_o  = '0;
    gnt_out_o = '0;
    found     = '0;
    for (int o = 0; o < 5; o++) begin
      sel_o[o] = rr_q[o];
      cand     = rr_q[o];
      // first requester at or after the pointer
      for (int k = 0; k < 5; k++) begin
        if (!found[o] && req_i[cand][o]) begin
          found[o] = 1'b1;
          sel_o[o] = cand;
        end
        cand = port_inc(cand);
      end
      // no downstream space means no grant at all
      gnt_out_o[o] = found[o] && credit_ok_i[o];
      // inputs request only one output, so winners never collide
      if (gnt_out_o[o]) begin
        gnt_in_o[sel_o[o]] = 1'b1;
      end
    end
  end

  // pointer moves just past the winner
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int o = 0; o < 5; o++) begin
        rr_q[o] <= PORT_N;
      end
    end else begin
      for (int o = 0; o < 5; o++) begin
        if (gnt_out_o[o]) begin
          rr_q[o] <= port_inc(sel_o[o]);
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 5; i++) begin
      req_multi[i] = !$onehot0(req_i[i]);
    end
  end

  // route compute hands over at most one output per input
  a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    req_multi == '0);

  // one input per granted output, no input popped twice
  a_one_per_out: assert property (@(posedge clk) disable iff (!rst_n_i)
    $countones(gnt_in_o) == $countones(gnt_out_o));

endmodule

`default_nettype wire

//--- input_port.sv
// router input port
// flit fifo, xy route compute of the head flit, credit return upstream

`include "router_params.svh"

`default_nettype none

module input_port import router_pkg::*; #(
  parameter coord_t MY_X = '0,
  parameter coord_t MY_Y = '0
) (
  input  logic      clk,
  input  logic      rst_n_i,
  input  flit_t     flit_i,
  input  logic      pop_i,
  output flit_t     head_o,
  output port_vec_t req_o,
  output logic      credit_o
);

  localparam int PTR_W = $clog2(`ROUTER_FIFO_DEPTH);
  localparam logic [`ROUTER_CRED_W-1:0] FULL_CNT = `ROUTER_FIFO_DEPTH;

  typedef logic [PTR_W-1:0] ptr_t;

  localparam ptr_t LAST_PTR = ptr_t'(`ROUTER_FIFO_DEPTH - 1);

  flit_t                     mem_q [`ROUTER_FIFO_DEPTH];
  ptr_t                      wr_ptr_q;
  ptr_t                      rd_ptr_q;
  logic [`ROUTER_CRED_W-1:0] cnt_q;

  logic push;
  logic empty;
  logic full;

  assign push  = flit_i.valid;
  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == FULL_CNT);

  // flit storage, written at the write pointer
  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= flit_i;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // head is only meaningful while something is stored
  always_comb begin
    head_o       = mem_q[rd_ptr_q];
    head_o.valid = !empty;
  end

  // dimension-ordered: resolve x first, then y
  always_comb begin
    req_o = '0;
    if (!empty) begin
      if (head_o.dest_x > MY_X) begin
        req_o[PORT_E] = 1'b1;
      end else if (head_o.dest_x < MY_X) begin
        req_o[PORT_W] = 1'b1;
      end else if (head_o.dest_y > MY_Y) begin
        req_o[PORT_N] = 1'b1;
      end else if (head_o.dest_y < MY_Y) begin
        req_o[PORT_S] = 1'b1;
      end else begin
        req_o[PORT_L] = 1'b1;
      end
    end
  end

  // each departing flit frees one upstream credit
  assign credit_o = pop_i;

  // upstream must respect its credits, allocator must see the request
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i) !(push && full));
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n_i) !(pop_i && empty));

endmodule

`default_nettype wire

//--- router_pkg.sv
// mesh router shared types
// port encoding, coordinate and payload widths, single-flit packet layout

`include "router_params.svh"

`default_nettype none

package router_pkg;

  // indexes every five-wide vector in the router
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_S = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_L = 3'd4
  } port_e;

  // one mesh coordinate, x or y
  typedef logic [`ROUTER_COORD_W-1:0] coord_t;

  typedef logic [`ROUTER_DATA_W-1:0] payload_t;

  // one bit per port: requests, grants, credits
  typedef logic [4:0] port_vec_t;

  // whole packet in one flit
  typedef struct packed {
    logic     valid;
    coord_t   dest_x;
    coord_t   dest_y;
    payload_t payload;
  } flit_t;

endpackage

`default_nettype wire

//--- router_params.svh
// mesh router sizing constants
// buffer depth, credit width, coordinate and payload widths

`ifndef ROUTER_PARAMS_SVH
`define ROUTER_PARAMS_SVH

// slots per input fifo, also the initial credits per output
`define ROUTER_FIFO_DEPTH 4

// wide enough to hold the full depth value
`define ROUTER_CRED_W 3

// bits per mesh x or y
`define ROUTER_COORD_W 2

// flit payload
`define ROUTER_DATA_W 16

`endif
